//--- build.f
design/aluPkg.sv
design/condPkg.sv
design/alu.sv
design/condCheck.sv
design/flagCommit.sv
design/dpExecute.sv
dv/dpExecute_chk.sv
dv/dpExecuteMon.sv
dv/dpExecuteTb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and decide on the pass message in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module dpExecuteTb -Mdir obj_dir || exit 1

out="$(./obj_dir/VdpExecuteTb 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Regression passed' && exit 0 || exit 1

//--- dv/dpExecuteTb.sv
`timescale 1ns/1ps

module dpExecuteTb;
    import aluPkg::*;
    import condPkg::*;

    localparam int clkPeriod = 40;
    localparam int resetCycles = 2;
    localparam int randomTxns = 400;
    // arith, carry-in arith, logical, test ops, conditions, long req.
    localparam int directedTxns = 75 + 300 + 60 + 20 + 192 + 1;
    localparam int txnCycles = 8;
    localparam int watchdogNs = (directedTxns + randomTxns) * txnCycles * clkPeriod;
    localparam int ackLimit = 16;  // cycles before a handshake counts as stuck.

    logic        clk;
    logic        arstN;
    logic        req;
    aluOp        opcode;
    condCode     cond;
    logic        setFlags;
    dataWord     srcA;
    dataWord     srcB;
    logic        ack;
    dataWord     result;
    logic        writeEn;
    nzcvFlags    flags;
    string       testName;
    int          tbErrors;

    dataWord boundary [5] = '{32'h0, 32'h1, 32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF};
    aluOp    carryOps [3] = '{ADC, SBC, RSC};
    aluOp    logicOps [6] = '{AND, EOR, ORR, MOV, BIC, MVN};
    aluOp    testOps [4] = '{TST, TEQ, CMP, CMN};
    // CMP operands giving ZC, N, C, CV, NV and NC.
    dataWord prepA [6] = '{32'h0, 32'h0, 32'h1, 32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFFF};
    dataWord prepB [6] = '{32'h0, 32'h1, 32'h0, 32'h1, 32'hFFFF_FFFF, 32'h1};

    dpExecute i_dut (.*);

    dpExecuteMon i_mon (.*);

    bind dpExecute dpExecute_chk i_chk (
        .clk   (clk),
        .arstN (arstN),
        .req   (req),
        .ack   (ack),
        .flags (flags)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // four-phase requester.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic runTxn(input aluOp op, input condCode c, input logic sf,
            input dataWord a, input dataWord b, input int holdCycles);
        int waited;
        @(negedge clk);
        opcode = op;
        cond = c;
        setFlags = sf;
        srcA = a;
        srcB = b;
        req = 1'b1;
        waited = 0;
        while (!ack && waited < ackLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            tbErrors++;
            $display("ack never rose after req in test %s", testName);
        end else if (waited != 1) begin
            tbErrors++;
            $display("[ERROR] %s: ack latency expected 1 actual %0d", testName, waited);
        end
        repeat (holdCycles) begin
            @(negedge clk);
            if (!ack) begin
                tbErrors++;
                $display("ack dropped while req was held high in test %s", testName);
            end
        end
        req = 1'b0;
        waited = 0;
        while (ack && waited < ackLimit) begin
            @(negedge clk);
            waited++;
        end
        if (ack) begin
            tbErrors++;
            $display("ack stayed high after req fell in test %s", testName);
        end
    endtask

    // CMP 0,0 leaves C set, CMP 0,1 clears it.
    task automatic setCarry(input logic carry);
        runTxn(CMP, AL, 1'b0, 32'd0, carry ? 32'd0 : 32'd1, 0);
    endtask

    task automatic randomTxn();
        logic [3:0] opDraw;
        logic [3:0] condDraw;
        dataWord    a;
        dataWord    b;
        opDraw = 4'($urandom_range(15, 0));
        condDraw = ($urandom_range(3, 0) == 0) ? 4'($urandom_range(15, 0)) : 4'(AL);
        a = ($urandom_range(3, 0) == 0) ? boundary[$urandom_range(4, 0)] : $urandom();
        b = ($urandom_range(3, 0) == 0) ? boundary[$urandom_range(4, 0)] : $urandom();
        runTxn(aluOp'(opDraw), condCode'(condDraw), 1'($urandom_range(1, 0)), a, b, 0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(32'h16b6));
        arstN = 1'b0;
        req = 1'b0;
        opcode = AND;
        cond = AL;
        setFlags = 1'b0;
        srcA = '0;
        srcB = '0;
        tbErrors = 0;
        testName = "reset";
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        if (ack !== 1'b0 || writeEn !== 1'b0 || flags !== 4'h0 || result !== '0) begin
            tbErrors++;
            $display("[ERROR] %s: ack/writeEn/flags/result expected 0/0/0/0 actual %0b/%0b/%0h/%0h",
                     testName, ack, writeEn, flags, result);
        end

        testName = "arithmetic";
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                runTxn(ADD, AL, 1'b1, boundary[i], boundary[j], 0);
                runTxn(SUB, AL, 1'b1, boundary[i], boundary[j], 0);
                runTxn(RSB, AL, 1'b1, boundary[i], boundary[j], 0);
                foreach (carryOps[k]) begin
                    for (int c = 0; c < 2; c++) begin
                        setCarry(c[0]);
                        runTxn(carryOps[k], AL, 1'b1, boundary[i], boundary[j], 0);
                    end
                end
            end
        end

        testName = "logical";
        foreach (logicOps[k]) begin
            for (int i = 0; i < 5; i++) begin
                runTxn(ADD, AL, 1'b1, 32'h8000_0000, 32'h8000_0000, 0);  // Z, C and V set.
                runTxn(logicOps[k], AL, 1'b1, boundary[i], boundary[4 - i], 0);
            end
        end

        testName = "test opcodes";
        foreach (testOps[k]) begin
            for (int i = 0; i < 5; i++) begin
                runTxn(testOps[k], AL, 1'b0, boundary[i], boundary[(i + 2) % 5], 0);
            end
        end

        testName = "conditions";
        foreach (prepA[p]) begin
            for (int c = 0; c < 16; c++) begin
                runTxn(CMP, AL, 1'b0, prepA[p], prepB[p], 0);
                runTxn(ADD, condCode'(c[3:0]), 1'b1, 32'd1, 32'd1, 0);
            end
        end

        testName = "handshake";
        runTxn(ADD, AL, 1'b1, 32'd5, 32'd7, 6);   // long req.

        testName = "random";
        repeat (randomTxns) randomTxn();

        repeat (2) @(negedge clk);
        if (i_mon.checkCount != directedTxns + randomTxns) begin
            tbErrors++;
            $display("the monitor compared %0d transactions but %0d were sent",
                     i_mon.checkCount, directedTxns + randomTxns);
        end
        $display("checks: %0d, monitor errors: %0d, testbench errors: %0d",
                 i_mon.checkCount, i_mon.errorCount, tbErrors);
        if (i_mon.errorCount == 0 && tbErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("timeout: the run did not finish within %0d ns", watchdogNs);
        $display("checks: %0d, monitor errors: %0d, testbench errors: %0d",
                 i_mon.checkCount, i_mon.errorCount, tbErrors);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- dv/dpExecuteMon.sv
`timescale 1ns/1ps

module dpExecuteMon (
    input logic              clk,
    input logic              ack,
    input aluPkg::aluOp      opcode,
    input condPkg::condCode  cond,
    input logic              setFlags,
    input aluPkg::dataWord   srcA,
    input aluPkg::dataWord   srcB,
    input aluPkg::dataWord   result,
    input logic              writeEn,
    input condPkg::nzcvFlags flags,
    input string             testName
);
    import aluPkg::*;
    import condPkg::*;

    int       errorCount = 0;
    int       checkCount = 0;
    nzcvFlags modelFlags = '0;   // flags as the model sees them.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // codes come in pairs, the odd one is the inverse.
    function automatic logic condHolds(input logic [3:0] c, input nzcvFlags f);
        logic base;
        case (c[3:1])
            3'd0: base = f[flagZ];
            3'd1: base = f[flagC];
            3'd2: base = f[flagN];
            3'd3: base = f[flagV];
            3'd4: base = f[flagC] & ~f[flagZ];
            3'd5: base = (f[flagN] == f[flagV]);
            3'd6: base = ~f[flagZ] & (f[flagN] == f[flagV]);
            default: return c == 4'd14;   // AL runs, NV never.
        endcase
        return base ^ c[0];
    endfunction

    // returns {new flags, writeEn, result}.
    function automatic logic [36:0] refModel(input logic [3:0] op, input logic [3:0] c,
            input logic sf, input dataWord a, input dataWord b, input nzcvFlags f);
        logic [32:0] wide;
        logic        isLogic;
        logic        isTest;
        logic        isSub;
        logic        pass;
        dataWord     x;
        dataWord     y;
        dataWord     res;
        nzcvFlags    nf;
        isLogic = op inside {4'd0, 4'd1, 4'd8, 4'd9, 4'd12, 4'd13, 4'd14, 4'd15};
        isTest = (op[3:2] == 2'b10);
        isSub = op inside {4'd2, 4'd3, 4'd6, 4'd7, 4'd10};
        x = (op == 4'd3 || op == 4'd7) ? b : a;   // reverse subtract.
        y = (op == 4'd3 || op == 4'd7) ? a : b;
        case (op)
            4'd2, 4'd3, 4'd10: wide = {1'b0, x} - {1'b0, y};
            4'd4, 4'd11:       wide = {1'b0, x} + {1'b0, y};
            4'd5:              wide = {1'b0, x} + {1'b0, y} + {32'd0, f[flagC]};
            4'd6, 4'd7:        wide = {1'b0, x} - {1'b0, y} - {32'd0, !f[flagC]};
            default:           wide = '0;
        endcase
        case (op)
            4'd0, 4'd8: res = a & b;
            4'd1, 4'd9: res = a ^ b;
            4'd12:      res = a | b;
            4'd13:      res = b;
            4'd14:      res = a & ~b;
            4'd15:      res = ~b;
            default:    res = wide[31:0];
        endcase
        pass = condHolds(c, f);
        nf = f;
        if (pass && (sf || isTest)) begin
            nf[flagN] = res[31];
            nf[flagZ] = (res == '0);
            if (!isLogic) begin
                nf[flagC] = isSub ? ~wide[32] : wide[32];   // carry means no borrow.
                nf[flagV] = isSub ? (x[31] != y[31]) && (res[31] != x[31])
                                  : (x[31] == y[31]) && (res[31] != x[31]);
            end
        end
        return {nf, pass && !isTest, res};
    endfunction

    task automatic compareField(input string field, input logic [31:0] expected,
            input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h",
                     testName, field, expected, actual);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare once per transaction.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : compare
        logic [36:0] expected;
        forever begin
            @(posedge ack);
            @(negedge clk);   // inputs held until ack falls.
            expected = refModel(opcode, cond, setFlags, srcA, srcB, modelFlags);
            checkCount++;
            compareField("result", expected[31:0], result);
            compareField("writeEn", {31'd0, expected[32]}, {31'd0, writeEn});
            compareField("flags", {28'd0, expected[36:33]}, {28'd0, flags});
            modelFlags = expected[36:33];
        end
    end

endmodule

//--- dv/dpExecute_chk.sv
`timescale 1ns/1ps

module dpExecute_chk (
    input logic              clk,
    input logic              arstN,
    input logic              req,
    input logic              ack,
    input condPkg::nzcvFlags flags
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake timing.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ackLowInReset: assert property (@(posedge clk) !arstN |-> !ack)
        else $error("ack high while reset is asserted");

    // capture edge is req high with ack low.
    ackAfterCapture: assert property (@(posedge clk) disable iff (!arstN)
        (req && !ack) |=> ack)
        else $error("ack did not rise one cycle after the capture edge");

    ackDropAfterReq: assert property (@(posedge clk) disable iff (!arstN)
        (ack && !req) |=> !ack)
        else $error("ack did not fall one cycle after req fell");

    noSpuriousAck: assert property (@(posedge clk) disable iff (!arstN)
        (!req && !ack) |=> !ack)
        else $error("ack rose without a request");

    // flags move only on a capture.
    flagsStableOnAck: assert property (@(posedge clk) disable iff (!arstN)
        ack |=> $stable(flags))
        else $error("flags changed while ack was high");

endmodule

//--- design/dpExecute.sv
`timescale 1ns/1ps

module dpExecute (
    input  logic              clk,
    input  logic              arstN,
    input  logic              req,
    input  aluPkg::aluOp      opcode,
    input  condPkg::condCode  cond,
    input  logic              setFlags,
    input  aluPkg::dataWord   srcA,
    input  aluPkg::dataWord   srcB,
    output logic              ack,
    output aluPkg::dataWord   result,
    output logic              writeEn,
    output condPkg::nzcvFlags flags
);
    import aluPkg::*;
    import condPkg::*;

    dataWord  aluResult;
    nzcvFlags aluFlags;
    nzcvFlags storedFlags;
    logic     logicOp;
    logic     compareOp;
    logic     condPass;

    assign flags = storedFlags;

    // ALU and condition check run side by side.
    alu i_alu (
        .srcA      (srcA),
        .srcB      (srcB),
        .carryIn   (storedFlags[flagC]),   // stored C feeds ADC, SBC, RSC.
        .opcode    (opcode),
        .result    (aluResult),
        .nzcv      (aluFlags),
        .logicOp   (logicOp),
        .compareOp (compareOp)
    );

    condCheck i_condCheck (
        .cond     (cond),
        .flags    (storedFlags),
        .condPass (condPass)
    );

    flagCommit i_flagCommit (
        .clk         (clk),
        .arstN       (arstN),
        .req         (req),
        .ack         (ack),
        .condPass    (condPass),
        .logicOp     (logicOp),
        .compareOp   (compareOp),
        .setFlags    (setFlags),
        .aluResult   (aluResult),
        .aluFlags    (aluFlags),
        .result      (result),
        .writeEn     (writeEn),
        .storedFlags (storedFlags)
    );

endmodule

//--- design/flagCommit.sv
`timescale 1ns/1ps

module flagCommit (
    input  logic              clk,
    input  logic              arstN,
    input  logic              req,
    output logic              ack,
    input  logic              condPass,
    input  logic              logicOp,
    input  logic              compareOp,
    input  logic              setFlags,
    input  aluPkg::dataWord   aluResult,
    input  condPkg::nzcvFlags aluFlags,
    output aluPkg::dataWord   result,
    output logic              writeEn,
    output condPkg::nzcvFlags storedFlags
);
    import condPkg::*;

    commitState state;
    commitState stateNext;
    logic       capture;       // the capture edge is coming.
    logic       flagsUpdate;
    nzcvFlags   flagsNext;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // four-phase handshake.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign capture = (state == IDLE) && req;
    assign ack = (state != IDLE);

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: if (req) stateNext = BUSY;
            BUSY: stateNext = req ? DONE : IDLE;
            DONE: if (!req) stateNext = IDLE;   // hold while req stays high.
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // commit rule.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign flagsUpdate = capture && condPass && (setFlags || compareOp);

    // logical opcodes have no shifter carry, so C and V stay.
    always_comb begin
        flagsNext = storedFlags;
        if (logicOp) begin
            flagsNext[flagN] = aluFlags[flagN];
            flagsNext[flagZ] = aluFlags[flagZ];
        end else begin
            flagsNext = aluFlags;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
            writeEn <= 1'b0;
            storedFlags <= '0;
        end else begin
            if (capture) begin
                result <= aluResult;
                writeEn <= condPass && !compareOp;   // test opcodes never write.
            end
            if (flagsUpdate) begin
                storedFlags <= flagsNext;
            end
        end
    end

endmodule

//--- design/condCheck.sv
`timescale 1ns/1ps

module condCheck (
    input  condPkg::condCode  cond,
    input  condPkg::nzcvFlags flags,
    output logic              condPass
);
    import condPkg::*;

    logic n;
    logic z;
    logic c;
    logic v;

    assign n = flags[flagN];
    assign z = flags[flagZ];
    assign c = flags[flagC];
    assign v = flags[flagV];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ARM condition table.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        condPass = 1'b0;
        case (cond)
            EQ: condPass = z;
            NE: condPass = !z;
            CS: condPass = c;           // unsigned higher or same.
            CC: condPass = !c;
            MI: condPass = n;
            PL: condPass = !n;
            VS: condPass = v;
            VC: condPass = !v;
            HI: condPass = c && !z;     // unsigned higher.
            LS: condPass = !c || z;
            // signed compares from N equal to V.
            GE: condPass = (n == v);
            LT: condPass = (n != v);
            GT: condPass = !z && (n == v);
            LE: condPass = z || (n != v);
            AL: condPass = 1'b1;
            NV: condPass = 1'b0;        // never runs.
            default: condPass = 1'b0;
        endcase
    end

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
    input  aluPkg::dataWord   srcA,
    input  aluPkg::dataWord   srcB,
    input  logic              carryIn,
    input  aluPkg::aluOp      opcode,
    output aluPkg::dataWord   result,
    output condPkg::nzcvFlags nzcv,
    output logic              logicOp,
    output logic              compareOp
);
    import aluPkg::*;
    import condPkg::*;

    dataWord            addA;
    dataWord            addB;
    logic               addCin;
    logic [dataWidth:0] addSum;       // carry out in the top bit.
    dataWord            logicResult;

    assign logicOp = logicOpMask[opcode];
    assign compareOp = compareOpMask[opcode];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // adder operand and carry selection.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // subtraction is a + ~b + 1, with the stored carry
    // standing in for the 1 on SBC and RSC.
    always_comb begin
        addA = srcA;
        addB = srcB;
        addCin = 1'b0;
        case (opcode)
            SUB, CMP: begin
                addB = ~srcB;
                addCin = 1'b1;
            end
            RSB: begin
                addA = srcB;   // reversed operands.
                addB = ~srcA;
                addCin = 1'b1;
            end
            ADC: begin
                addCin = carryIn;
            end
            SBC: begin
                addB = ~srcB;
                addCin = carryIn;
            end
            RSC: begin
                addA = srcB;
                addB = ~srcA;
                addCin = carryIn;
            end
            default: begin
                addCin = 1'b0;   // ADD, CMN and logical.
            end
        endcase
    end

    assign addSum = {1'b0, addA} + {1'b0, addB} + {{dataWidth{1'b0}}, addCin};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // logic path.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (opcode)
            AND, TST: logicResult = srcA & srcB;
            EOR, TEQ: logicResult = srcA ^ srcB;
            ORR:      logicResult = srcA | srcB;
            MOV:      logicResult = srcB;
            BIC:      logicResult = srcA & ~srcB;
            MVN:      logicResult = ~srcB;
            default:  logicResult = '0;   // arithmetic, unused.
        endcase
    end

    assign result = logicOp ? logicResult : addSum[dataWidth-1:0];

    // candidate flags. C and V are only meaningful for arithmetic.
    always_comb begin
        nzcv = '0;
        nzcv[flagN] = result[dataWidth-1];
        nzcv[flagZ] = (result == '0);
        nzcv[flagC] = addSum[dataWidth];
        // same input signs, different sum sign.
        nzcv[flagV] = (addA[dataWidth-1] == addB[dataWidth-1])
                    && (addSum[dataWidth-1] != addA[dataWidth-1]);
    end

endmodule

//--- design/condPkg.sv
package condPkg;

    // N Z C V from the msb down.
    typedef logic [3:0] nzcvFlags;

    localparam int flagN = 3;
    localparam int flagZ = 2;
    localparam int flagC = 1;
    localparam int flagV = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ARM condition field.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        EQ = 4'd0,
        NE = 4'd1,
        CS = 4'd2,
        CC = 4'd3,
        MI = 4'd4,
        PL = 4'd5,
        VS = 4'd6,
        VC = 4'd7,
        HI = 4'd8,
        LS = 4'd9,
        GE = 4'd10,
        LT = 4'd11,
        GT = 4'd12,
        LE = 4'd13,
        AL = 4'd14,
        NV = 4'd15   // never.
    } condCode;

    // handshake states of the commit unit.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,  // just captured, ack high.
        DONE = 2'd2   // waiting for req low.
    } commitState;

endpackage

//--- design/aluPkg.sv
package aluPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths fixed by the instruction set.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int dataWidth = 32;
    localparam int opWidth = 4;

    typedef logic [dataWidth-1:0] dataWord;  // operand and result word.

    // ARM data-processing opcode field.
    typedef enum logic [opWidth-1:0] {
        AND = 4'd0,
        EOR = 4'd1,
        SUB = 4'd2,
        RSB = 4'd3,
        ADD = 4'd4,
        ADC = 4'd5,
        SBC = 4'd6,
        RSC = 4'd7,
        TST = 4'd8,   // AND, flags only.
        TEQ = 4'd9,   // EOR, flags only.
        CMP = 4'd10,  // SUB, flags only.
        CMN = 4'd11,  // ADD, flags only.
        ORR = 4'd12,
        MOV = 4'd13,
        BIC = 4'd14,
        MVN = 4'd15
    } aluOp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcode classes, one bit per opcode value.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // logical: AND EOR TST TEQ ORR MOV BIC MVN.
    localparam logic [2**opWidth-1:0] logicOpMask = 16'hF303;
    // test opcodes: TST TEQ CMP CMN, no register write.
    localparam logic [2**opWidth-1:0] compareOpMask = 16'h0F00;

endpackage
